// File: sources.f
executePkg.sv
executeControl.sv
operandForward.sv
integerAlu.sv
fpAddUnit.sv
executeStage.sv
executeStageTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module executeStageTb -f sources.f -Mdir obj_dir > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Build failed"
    exit 1
fi

./obj_dir/VexecuteStageTb > "$SIM_LOG" 2>&1
simStatus=$?
cat "$SIM_LOG"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -qF "*** TEST PASSED ***" "$SIM_LOG"; then
    exit 0
fi
exit 1

// File: executeStageTb.sv
module executeStageTb import executePkg::*;;

    localparam int DataWidth     = 32;
    localparam int RegAddrWidth  = 5;
    localparam int FloatWidth    = 1 + fpExpWidth + fpManWidth;
    localparam int NumEntries    = 26;
    localparam int TimeoutCycles = 10 * NumEntries + 50;

    // One table row per issued op
    typedef struct packed {
        execOp                   op;
        logic [RegAddrWidth-1:0] rs1Num;
        logic [DataWidth-1:0]    rs1Data;
        logic [RegAddrWidth-1:0] rs2Num;
        logic [DataWidth-1:0]    rs2Data;
        logic [RegAddrWidth-1:0] rd;
        logic                    regWrite;
        logic [RegAddrWidth-1:0] wbRd;
        logic                    wbRegWrite;
        logic [DataWidth-1:0]    wbResult;
        logic [3:0]              hold;
        logic [FloatWidth-1:0]   expFloat;
    } stimEntry;

    logic                    clk;
    logic                    reset;
    logic                    issue;
    execOp                   op;
    logic [RegAddrWidth-1:0] rs1Num;
    logic [RegAddrWidth-1:0] rs2Num;
    logic [DataWidth-1:0]    rs1Data;
    logic [DataWidth-1:0]    rs2Data;
    logic [RegAddrWidth-1:0] rd;
    logic                    regWrite;
    logic [RegAddrWidth-1:0] wbRd;
    logic [DataWidth-1:0]    wbResult;
    logic                    wbRegWrite;
    logic                    memHold;
    logic                    stall;
    logic                    exValid;
    logic [RegAddrWidth-1:0] exRd;
    logic                    exRegWrite;
    logic [DataWidth-1:0]    exResult;

    stimEntry stimTable [0:NumEntries-1];
    integer   seed;
    int       mismatchErrors = 0;
    int       otherErrors = 0;
    int       cycleCount = 0;

    // Reference copy of the EX/MEM register
    logic [RegAddrWidth-1:0] modelExRd;
    logic [DataWidth-1:0]    modelExResult;
    logic                    modelExRegWrite;

    executeStage #(
        .DataWidth    (DataWidth),
        .RegAddrWidth (RegAddrWidth)
    ) u_executeStage (
        .clk        (clk),
        .reset      (reset),
        .issue      (issue),
        .op         (op),
        .rs1Num     (rs1Num),
        .rs2Num     (rs2Num),
        .rs1Data    (rs1Data),
        .rs2Data    (rs2Data),
        .rd         (rd),
        .regWrite   (regWrite),
        .wbRd       (wbRd),
        .wbResult   (wbResult),
        .wbRegWrite (wbRegWrite),
        .memHold    (memHold),
        .stall      (stall),
        .exValid    (exValid),
        .exRd       (exRd),
        .exRegWrite (exRegWrite),
        .exResult   (exResult)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Hard cycle limit
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    // Next drive point, 2 units after the edge
    task automatic stepCycle();
        @(posedge clk);
        #2;
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            $display("Mismatch at time %0t: %s got %0h, expected %0h",
                     $time, name, got, expected);
            mismatchErrors++;
        end
    endtask

    task automatic setEntry(
        input int idx, input execOp eOp,
        input logic [4:0] eRs1Num, input logic [31:0] eRs1Data,
        input logic [4:0] eRs2Num, input logic [31:0] eRs2Data,
        input logic [4:0] eRd, input logic eRegWrite,
        input logic [4:0] eWbRd, input logic eWbRegWrite, input logic [31:0] eWbResult,
        input logic [3:0] eHold, input logic [31:0] eExpFloat
    );
        stimTable[idx] = {eOp, eRs1Num, eRs1Data, eRs2Num, eRs2Data, eRd, eRegWrite,
                          eWbRd, eWbRegWrite, eWbResult, eHold, eExpFloat};
    endtask

    // Integer rules, RV32 semantics
    function automatic logic [31:0] aluModel(input execOp eOp, input logic [31:0] a,
                                             input logic [31:0] b);
        case (eOp)
            opAdd:   return a + b;
            opSub:   return a - b;
            opAnd:   return a & b;
            opOr:    return a | b;
            opXor:   return a ^ b;
            opSll:   return a << b[4:0];
            opSrl:   return a >> b[4:0];
            opSra:   return $unsigned($signed(a) >>> b[4:0]);
            opSlt:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            opSltu:  return (a < b) ? 32'd1 : 32'd0;
            default: return 32'd0;
        endcase
    endfunction

    // EX/MEM beats writeback, x0 never forwards
    function automatic logic [31:0] forwardModel(input logic [4:0] num,
                                                 input logic [31:0] data, input stimEntry e);
        if (modelExRegWrite && modelExRd != 0 && modelExRd == num) begin
            return modelExResult;
        end
        if (e.wbRegWrite && e.wbRd != 0 && e.wbRd == num) begin
            return e.wbResult;
        end
        return data;
    endfunction

    task automatic driveEntry(input stimEntry e);
        issue      = 1'b1;
        op         = e.op;
        rs1Num     = e.rs1Num;
        rs2Num     = e.rs2Num;
        rs1Data    = e.rs1Data;
        rs2Data    = e.rs2Data;
        rd         = e.rd;
        regWrite   = e.regWrite;
        wbRd       = e.wbRd;
        wbRegWrite = e.wbRegWrite;
        wbResult   = e.wbResult;
    endtask

    //////////////////////////////////////////////////
    // Per-entry runs
    //////////////////////////////////////////////////

    task automatic runInteger(input stimEntry e);
        logic [31:0] expected;
        logic        heldValid;
        logic [31:0] heldResult;
        expected = aluModel(e.op, forwardModel(e.rs1Num, e.rs1Data, e),
                            forwardModel(e.rs2Num, e.rs2Data, e));
        heldValid  = exValid;
        heldResult = exResult;
        driveEntry(e);
        memHold = (e.hold != 0);
        // Issue stays up while held
        for (int h = 0; h < e.hold; h++) begin
            stepCycle();
            checkValue("exValid", exValid, heldValid);
            checkValue("exResult", exResult, heldResult);
            if (h == e.hold - 1) begin
                memHold = 1'b0;
            end
        end
        stepCycle();
        checkValue("exValid", exValid, 1);
        checkValue("exResult", exResult, expected);
        checkValue("exRd", exRd, e.rd);
        checkValue("exRegWrite", exRegWrite, e.regWrite);
        checkValue("stall", stall, 0);
        modelExRd       = e.rd;
        modelExResult   = expected;
        modelExRegWrite = e.regWrite;
    endtask

    task automatic runFloat(input stimEntry e);
        int          stallCount;
        int          heldLeft;
        logic [31:0] heldResult;
        stallCount = 0;
        heldLeft   = e.hold;
        heldResult = exResult;
        driveEntry(e);
        memHold = 1'b0;
        stepCycle();
        // Busy window, ends with the capture
        while (stall) begin
            stallCount++;
            if (exValid !== 1'b0) begin
                $display("Error at time %0t: exValid was high while stall was high", $time);
                otherErrors++;
            end
            checkValue("exResult", exResult, heldResult);
            // Upstream pushes another op, must be dropped
            issue    = 1'b1;
            op       = opAdd;
            rd       = 5'd31;
            regWrite = !e.regWrite;
            rs1Data  = $random(seed);
            rs2Data  = $random(seed);
            memHold  = (heldLeft > 0);
            if (heldLeft > 0) begin
                heldLeft--;
            end
            stepCycle();
        end
        checkValue("stall cycles", stallCount, 4 + e.hold);
        checkValue("exValid", exValid, 1);
        checkValue("exResult", exResult, e.expFloat);
        checkValue("exRd", exRd, e.rd);
        checkValue("exRegWrite", exRegWrite, e.regWrite);
        modelExRd       = e.rd;
        modelExResult   = e.expFloat;
        modelExRegWrite = e.regWrite;
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        reset      = 1'b1;
        issue      = 1'b0;
        op         = opAdd;
        rs1Num     = '0;
        rs2Num     = '0;
        rs1Data    = '0;
        rs2Data    = '0;
        rd         = '0;
        regWrite   = 1'b0;
        wbRd       = '0;
        wbResult   = '0;
        wbRegWrite = 1'b0;
        memHold    = 1'b0;
        modelExRd       = '0;
        modelExResult   = '0;
        modelExRegWrite = 1'b0;
        seed = 74776;

        // Integer ops, chained through EX/MEM
        setEntry(0, opAdd, 1, $random(seed), 2, $random(seed), 3, 1, 0, 0, 0, 0, 0);
        setEntry(1, opSub, 3, $random(seed), 2, $random(seed), 4, 1, 0, 0, 0, 0, 0);
        setEntry(2, opAnd, 4, $random(seed), 5, $random(seed), 5, 1, 0, 0, 0, 0, 0);
        setEntry(3, opOr, 5, $random(seed), 6, $random(seed), 6, 1, 0, 0, 0, 0, 0);
        setEntry(4, opXor, 6, $random(seed), 7, $random(seed), 7, 1, 0, 0, 0, 0, 0);
        setEntry(5, opSll, 8, $random(seed), 9, $random(seed), 8, 1, 0, 0, 0, 0, 0);
        setEntry(6, opSrl, 8, $random(seed), 9, 32'd7, 9, 1, 0, 0, 0, 0, 0);
        setEntry(7, opSra, 10, 32'hF0F0_0000, 11, 32'd4, 10, 1, 0, 0, 0, 0, 0);
        setEntry(8, opSlt, 10, $random(seed), 11, 32'd1, 11, 1, 0, 0, 0, 0, 0);
        // Same operands, signed vs unsigned
        setEntry(9, opSlt, 12, 32'h8000_0000, 13, 32'd1, 12, 1, 0, 0, 0, 0, 0);
        setEntry(10, opSltu, 14, 32'h8000_0000, 15, 32'd1, 13, 1, 0, 0, 0, 0, 0);
        // Writeback only
        setEntry(11, opAdd, 20, $random(seed), 21, $random(seed), 14, 1,
                 20, 1, $random(seed), 0, 0);
        // Both ports match rs1
        setEntry(12, opXor, 14, $random(seed), 22, $random(seed), 15, 1,
                 14, 1, $random(seed), 0, 0);
        // x0 as destination, then as source
        setEntry(13, opAdd, 0, $random(seed), 0, $random(seed), 0, 1, 0, 0, 0, 0, 0);
        setEntry(14, opOr, 0, $random(seed), 23, $random(seed), 18, 1,
                 0, 1, $random(seed), 0, 0);
        // No write, so no forward next
        setEntry(15, opAdd, 18, $random(seed), 23, $random(seed), 19, 0, 0, 0, 0, 0, 0);
        setEntry(16, opSub, 19, $random(seed), 18, $random(seed), 20, 1, 0, 0, 0, 2, 0);
        setEntry(17, opAnd, 20, $random(seed), 24, $random(seed), 22, 1, 0, 0, 0, 1, 0);
        // Float, hand-worked truncated results
        setEntry(18, opFadd, 25, 32'h408C_CCCD, 26, 32'h400C_CCCD, 16, 1, 0, 0, 0, 0,
                 32'h40D3_3333);
        setEntry(19, opFsub, 25, 32'h408C_CCCD, 26, 32'h400C_CCCD, 17, 1, 0, 0, 0, 0,
                 32'h400C_CCCE);
        setEntry(20, opFsub, 25, 32'h400C_CCCD, 26, 32'h408C_CCCD, 18, 1, 0, 0, 0, 3,
                 32'hC00C_CCCE);
        setEntry(21, opFadd, 25, 32'h4040_0000, 26, 32'h3F00_0000, 19, 1, 0, 0, 0, 1,
                 32'h4060_0000);
        setEntry(22, opFsub, 25, 32'h3FC0_0000, 26, 32'h3FC0_0000, 21, 1, 0, 0, 0, 0,
                 32'h0000_0000);
        // Underflow to negative zero, then a mantissa carry out
        setEntry(23, opFsub, 25, 32'h0080_0000, 26, 32'h00C0_0000, 24, 1, 0, 0, 0, 0,
                 32'h8000_0000);
        setEntry(24, opFadd, 25, 32'h3FC0_0000, 26, 32'h3FC0_0000, 21, 1, 0, 0, 0, 0,
                 32'h4040_0000);
        // Float result forwarded into integer op
        setEntry(25, opAdd, 21, $random(seed), 19, $random(seed), 23, 1, 0, 0, 0, 0, 0);

        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        checkValue("stall", stall, 0);
        checkValue("exValid", exValid, 0);
        checkValue("exRegWrite", exRegWrite, 0);

        for (int i = 0; i < NumEntries; i++) begin
            if (stimTable[i].op == opFadd || stimTable[i].op == opFsub) begin
                runFloat(stimTable[i]);
            end else begin
                runInteger(stimTable[i]);
            end
        end

        // Idle cycle drops exValid
        issue = 1'b0;
        stepCycle();
        checkValue("exValid", exValid, 0);

        $display("Errors: %0d mismatches, %0d other failures", mismatchErrors, otherErrors);
        if (mismatchErrors == 0 && otherErrors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: executeStage.sv
module executeStage import executePkg::*; #(
    parameter int DataWidth    = 32,
    parameter int RegAddrWidth = 5
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    issue,
    input  execOp                   op,
    input  logic [RegAddrWidth-1:0] rs1Num,
    input  logic [RegAddrWidth-1:0] rs2Num,
    input  logic [DataWidth-1:0]    rs1Data,
    input  logic [DataWidth-1:0]    rs2Data,
    input  logic [RegAddrWidth-1:0] rd,
    input  logic                    regWrite,
    input  logic [RegAddrWidth-1:0] wbRd,
    input  logic [DataWidth-1:0]    wbResult,
    input  logic                    wbRegWrite,
    input  logic                    memHold,
    output logic                    stall,
    output logic                    exValid,
    output logic [RegAddrWidth-1:0] exRd,
    output logic                    exRegWrite,
    output logic [DataWidth-1:0]    exResult
);

    logic                    fpStart;
    logic                    fpDone;
    logic                    captureInt;
    logic                    captureFp;
    logic [DataWidth-1:0]    opA;
    logic [DataWidth-1:0]    opB;
    logic [DataWidth-1:0]    aluResult;
    // Float unit is fixed at single precision, DataWidth stays 32
    logic [fpWidth-1:0]      fpResult;
    logic [RegAddrWidth-1:0] fpRd;
    logic                    fpRegWrite;

    //////////////////////////////////////////////////
    // Units
    //////////////////////////////////////////////////

    executeControl u_executeControl (
        .clk        (clk),
        .reset      (reset),
        .issue      (issue),
        .op         (op),
        .memHold    (memHold),
        .fpDone     (fpDone),
        .fpStart    (fpStart),
        .stall      (stall),
        .captureInt (captureInt),
        .captureFp  (captureFp)
    );

    operandForward #(
        .DataWidth    (DataWidth),
        .RegAddrWidth (RegAddrWidth)
    ) u_operandForward (
        .rs1Num     (rs1Num),
        .rs2Num     (rs2Num),
        .rs1Data    (rs1Data),
        .rs2Data    (rs2Data),
        .exRd       (exRd),
        .exRegWrite (exRegWrite),
        .exResult   (exResult),
        .wbRd       (wbRd),
        .wbRegWrite (wbRegWrite),
        .wbResult   (wbResult),
        .opA        (opA),
        .opB        (opB)
    );

    integerAlu #(
        .DataWidth (DataWidth)
    ) u_integerAlu (
        .op        (op),
        .opA       (opA),
        .opB       (opB),
        .aluResult (aluResult)
    );

    fpAddUnit u_fpAddUnit (
        .clk      (clk),
        .reset    (reset),
        .memHold  (memHold),
        .fpStart  (fpStart),
        .subtract (op == opFsub),
        .opA      (opA),
        .opB      (opB),
        .fpDone   (fpDone),
        .fpResult (fpResult)
    );

    //////////////////////////////////////////////////
    // Float destination and EX/MEM register
    //////////////////////////////////////////////////

    // Inputs may change during the stall, keep rd now
    always_ff @(posedge clk) begin
        if (fpStart) begin
            fpRd <= rd;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fpRegWrite <= 1'b0;
            exValid    <= 1'b0;
            exRegWrite <= 1'b0;
        end else begin
            if (fpStart) begin
                fpRegWrite <= regWrite;
            end
            // Held cycles keep exValid as is
            if (!memHold) begin
                exValid <= captureInt || captureFp;
            end
            if (captureInt) begin
                exRegWrite <= regWrite;
            end else if (captureFp) begin
                exRegWrite <= fpRegWrite;
            end
        end
    end

    // Payload, loads only on a capture
    always_ff @(posedge clk) begin
        if (captureInt) begin
            exRd     <= rd;
            exResult <= aluResult;
        end else if (captureFp) begin
            exRd     <= fpRd;
            exResult <= fpResult;
        end
    end

    // ALU result only captured for integer ops
    assert property (@(posedge clk) disable iff (reset) captureInt |-> !isFloatOp(op));

endmodule

// File: fpAddUnit.sv
module fpAddUnit import executePkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               memHold,
    input  logic               fpStart,
    input  logic               subtract,
    input  logic [fpWidth-1:0] opA,
    input  logic [fpWidth-1:0] opB,
    output logic               fpDone,
    output logic [fpWidth-1:0] fpResult
);

    // Mantissa with hidden bit
    localparam int ManBits = fpManWidth + 1;
    localparam int LzWidth = $clog2(ManBits + 1);

    function automatic logic [LzWidth-1:0] leadZeros(input logic [ManBits-1:0] value);
        logic [LzWidth-1:0] count;
        logic               found;
        count = '0;
        found = 1'b0;
        for (int i = ManBits - 1; i >= 0; i--) begin
            if (!found) begin
                if (value[i]) begin
                    found = 1'b1;
                end else begin
                    count = count + 1'b1;
                end
            end
        end
        return count;
    endfunction

    //////////////////////////////////////////////////
    // Align stage
    //////////////////////////////////////////////////

    logic                  signA;
    logic                  signB;
    logic                  aBig;
    logic [fpExpWidth-1:0] expA;
    logic [fpExpWidth-1:0] expB;
    logic [ManBits-1:0]    manA;
    logic [ManBits-1:0]    manB;
    logic [fpExpWidth-1:0] expDiff;

    logic                  alnValid;
    logic                  alnSign;
    logic                  alnSub;
    logic [fpExpWidth-1:0] alnExp;
    logic [ManBits-1:0]    alnManBig;
    logic [ManBits-1:0]    alnManSmall;

    assign signA = opA[fpWidth-1];
    assign signB = opB[fpWidth-1] ^ subtract;
    assign expA  = opA[fpWidth-2:fpManWidth];
    assign expB  = opB[fpWidth-2:fpManWidth];
    // Hidden bit only for a nonzero exponent, so a zero operand adds nothing
    assign manA  = {|expA, opA[fpManWidth-1:0]};
    assign manB  = {|expB, opB[fpManWidth-1:0]};
    // Larger magnitude goes first
    assign aBig    = opA[fpWidth-2:0] >= opB[fpWidth-2:0];
    assign expDiff = aBig ? (expA - expB) : (expB - expA);

    always_ff @(posedge clk) begin
        if (!memHold) begin
            alnSign     <= aBig ? signA : signB;
            alnSub      <= signA ^ signB;
            alnExp      <= aBig ? expA : expB;
            alnManBig   <= aBig ? manA : manB;
            // Shifted-out bits dropped
            alnManSmall <= (aBig ? manB : manA) >> expDiff;
        end
    end

    //////////////////////////////////////////////////
    // Add stage
    //////////////////////////////////////////////////

    logic                  sumValid;
    logic                  sumSign;
    logic [fpExpWidth-1:0] sumExp;
    logic [ManBits:0]      sumMan;

    always_ff @(posedge clk) begin
        if (!memHold) begin
            sumSign <= alnSign;
            sumExp  <= alnExp;
            // Small never exceeds big, so no borrow
            sumMan  <= alnSub ? ({1'b0, alnManBig} - {1'b0, alnManSmall})
                              : ({1'b0, alnManBig} + {1'b0, alnManSmall});
        end
    end

    //////////////////////////////////////////////////
    // Normalize stage
    //////////////////////////////////////////////////

    logic [LzWidth-1:0]           lz;
    logic [fpExpWidth+1:0]        lzWide;
    logic signed [fpExpWidth+1:0] expWide;
    logic signed [fpExpWidth+1:0] normExp;
    logic [ManBits-1:0]           normMan;
    logic [fpWidth-1:0]           normResult;

    always_comb begin
        lz      = leadZeros(sumMan[ManBits-1:0]);
        lzWide  = lz;
        expWide = {2'b00, sumExp};
        if (sumMan[ManBits]) begin
            // Carry out, one right shift
            normMan = sumMan[ManBits:1];
            normExp = expWide + 1'b1;
        end else begin
            normMan = sumMan[ManBits-1:0] << lz;
            normExp = expWide - lzWide;
        end
        if (sumMan == '0) begin
            normResult = '0;
        end else if (normExp < 1) begin
            // Underflow gives signed zero
            normResult = {sumSign, {(fpWidth-1){1'b0}}};
        end else begin
            normResult = {sumSign, normExp[fpExpWidth-1:0], normMan[fpManWidth-1:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (!memHold && sumValid) begin
            fpResult <= normResult;
        end
    end

    // Valid bits, one per stage
    always_ff @(posedge clk) begin
        if (reset) begin
            alnValid <= 1'b0;
            sumValid <= 1'b0;
            fpDone   <= 1'b0;
        end else if (!memHold) begin
            alnValid <= fpStart;
            sumValid <= alnValid;
            fpDone   <= sumValid;
        end
    end

endmodule

// File: integerAlu.sv
module integerAlu import executePkg::*; #(
    parameter int DataWidth = 32
) (
    input  execOp                op,
    input  logic [DataWidth-1:0] opA,
    input  logic [DataWidth-1:0] opB,
    output logic [DataWidth-1:0] aluResult
);

    logic [4:0] shamt;
    logic       lessSigned;
    logic       lessUnsigned;

    // RV32 shifts use the low five bits only
    assign shamt = opB[4:0];

    assign lessSigned   = $signed(opA) < $signed(opB);
    assign lessUnsigned = opA < opB;

    //////////////////////////////////////////////////
    // Result select
    //////////////////////////////////////////////////

    always_comb begin
        case (op)
            opAdd: aluResult = opA + opB;
            opSub: aluResult = opA - opB;
            opAnd: aluResult = opA & opB;
            opOr:  aluResult = opA | opB;
            opXor: aluResult = opA ^ opB;
            opSll: aluResult = opA << shamt;
            opSrl: aluResult = opA >> shamt;
            // Arithmetic shift keeps the sign bit
            opSra: aluResult = $signed(opA) >>> shamt;
            // Compares write 1 or 0
            opSlt: begin
                aluResult    = '0;
                aluResult[0] = lessSigned;
            end
            opSltu: begin
                aluResult    = '0;
                aluResult[0] = lessUnsigned;
            end
            // Float ops never captured from here
            default: aluResult = '0;
        endcase
    end

endmodule

// File: operandForward.sv
module operandForward #(
    parameter int DataWidth    = 32,
    parameter int RegAddrWidth = 5
) (
    input  logic [RegAddrWidth-1:0] rs1Num,
    input  logic [RegAddrWidth-1:0] rs2Num,
    input  logic [DataWidth-1:0]    rs1Data,
    input  logic [DataWidth-1:0]    rs2Data,
    input  logic [RegAddrWidth-1:0] exRd,
    input  logic                    exRegWrite,
    input  logic [DataWidth-1:0]    exResult,
    input  logic [RegAddrWidth-1:0] wbRd,
    input  logic                    wbRegWrite,
    input  logic [DataWidth-1:0]    wbResult,
    output logic [DataWidth-1:0]    opA,
    output logic [DataWidth-1:0]    opB
);

    // One operand: EX/MEM first, then writeback, else register file
    function automatic logic [DataWidth-1:0] pickOperand(
        input logic [RegAddrWidth-1:0] num,
        input logic [DataWidth-1:0]    data
    );
        logic exHit;
        logic wbHit;
        // x0 never matches
        exHit = exRegWrite && (exRd != '0) && (exRd == num);
        wbHit = wbRegWrite && (wbRd != '0) && (wbRd == num);
        if (exHit) begin
            return exResult;
        end else if (wbHit) begin
            return wbResult;
        end
        return data;
    endfunction

    always_comb begin
        opA = pickOperand(rs1Num, rs1Data);
        opB = pickOperand(rs2Num, rs2Data);
    end

endmodule

// File: executeControl.sv
module executeControl import executePkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  issue,
    input  execOp op,
    input  logic  memHold,
    input  logic  fpDone,
    output logic  fpStart,
    output logic  stall,
    output logic  captureInt,
    output logic  captureFp
);

    ctlState state;
    ctlState nextState;

    //////////////////////////////////////////////////
    // Next state and strobes
    //////////////////////////////////////////////////

    always_comb begin
        fpStart    = 1'b0;
        captureInt = 1'b0;
        captureFp  = 1'b0;
        nextState  = state;
        case (state)
            ctlIdle: begin
                // Issue only taken when not held
                if (issue && !memHold) begin
                    if (isFloatOp(op)) begin
                        fpStart   = 1'b1;
                        nextState = ctlFpBusy;
                    end else begin
                        captureInt = 1'b1;
                    end
                end
            end
            ctlFpBusy: begin
                // Wait for normalize stage
                if (fpDone && !memHold) begin
                    nextState = ctlFpDone;
                end
            end
            ctlFpDone: begin
                if (!memHold) begin
                    captureFp = 1'b1;
                    nextState = ctlIdle;
                end
            end
            default: nextState = ctlIdle;
        endcase
    end

    // State frozen on memHold, so stall holds too
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ctlIdle;
        end else if (!memHold) begin
            state <= nextState;
        end
    end

    // Stall covers the whole float run, including the capture cycle
    assign stall = (state != ctlIdle);

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    assert property (@(posedge clk) disable iff (reset) (state == ctlFpBusy) |-> !fpStart);

    assert property (@(posedge clk) disable iff (reset) !(captureInt && captureFp));

endmodule

// File: executePkg.sv
package executePkg;

    //////////////////////////////////////////////////
    // Operation encodings
    //////////////////////////////////////////////////

    // Integer ops first, float ops last
    typedef enum logic [3:0] {
        opAdd,
        opSub,
        opAnd,
        opOr,
        opXor,
        opSll,
        opSrl,
        opSra,
        opSlt,
        opSltu,
        opFadd,
        opFsub
    } execOp;

    // Control FSM states
    typedef enum logic [1:0] {
        ctlIdle,
        ctlFpBusy,
        ctlFpDone
    } ctlState;

    //////////////////////////////////////////////////
    // Single-precision field widths
    //////////////////////////////////////////////////

    parameter int fpExpWidth = 8;
    parameter int fpManWidth = 23;
    parameter int fpWidth    = 1 + fpExpWidth + fpManWidth;

    // True for ops that go to the float unit
    function automatic logic isFloatOp(input execOp op);
        return (op == opFadd) || (op == opFsub);
    endfunction

endpackage
